/* project.f */
+incdir+verilog
verilog/displayPkg.sv
verilog/pulseCounter.sv
verilog/binToBcd.sv
verilog/segmentDecoder.sv
verilog/displayScan.sv
verilog/displayCounterTop.sv
verif/displayCounterTb.sv

/* verif/displayCounterTb.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module displayCounterTb;

   localparam int clkPeriod      = 8;
   localparam int numTests       = 11;
   localparam int fieldsPerTest  = 6;
   localparam int settleCycles   = 64 + 4 * `SCAN_PERIOD;
   localparam int scanCycles     = 4 * `SCAN_PERIOD;
   localparam int maxPulseCycles = 5 + 9;

   logic        clk;
   logic        rstN;
   logic        evento;
   logic        clear;
   logic [7:0]  catodo;
   logic [3:0]  anodo;

   logic [15:0] testMem [0:numTests*fieldsPerTest-1];
   logic [31:0] rngState;
   int          testsPassed;
   int          testsFailed;

   displayCounterTop displayCounterTop_inst (
      .clk    (clk),
      .rstN   (rstN),
      .evento (evento),
      .clear  (clear),
      .catodo (catodo),
      .anodo  (anodo)
   );

   initial begin
      clk = 1'b0;
      forever begin
         #(clkPeriod / 2) clk = ~clk;
      end
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x;
      y = y ^ (y << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   // Inputs move 1 ns after the rising edge.
   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic applyClear();
      clear = 1'b1;
      nextCycle();
      clear = 1'b0;
   endtask

   task automatic sendPulses(input int pulseCount);
      int highCycles;
      int lowCycles;
      for (int i = 0; i < pulseCount; i++) begin
         rngState   = xorshift32(rngState);
         highCycles = 2 + int'(rngState % 4);
         rngState   = xorshift32(rngState);
         lowCycles  = 4 + int'(rngState % 6);
         evento = 1'b1;
         repeat (highCycles) nextCycle();
         evento = 1'b0;
         repeat (lowCycles) nextCycle();
      end
   endtask

   // ==================================================
   // One full scan sampled on the falling edge
   // ==================================================

   task automatic checkScan(input int base, output int errs);
      logic [7:0] expected [0:3];
      bit         seen [0:3];
      int         pos;
      errs = 0;
      // Columns 2 to 5 hold the thousands digit down to the ones digit.
      for (int p = 0; p < 4; p++) begin
         expected[p] = testMem[base + 5 - p][7:0];
         seen[p]     = 1'b0;
      end
      repeat (scanCycles) begin
         @(negedge clk);
         if ($countones(anodo) != 3) begin
            $display("Error at %0t ns: not exactly one anodo bit is low, anodo is %b",
                     $time, anodo);
            errs++;
         end else begin
            pos = 0;
            for (int p = 0; p < 4; p++) begin
               if (!anodo[p]) begin
                  pos = p;
               end
            end
            seen[pos] = 1'b1;
            if (catodo !== expected[pos]) begin
               $display("FAIL at %0t ns: catodo (digit %0d) expected %b, got %b",
                        $time, pos, expected[pos], catodo);
               errs++;
            end
         end
      end
      for (int p = 0; p < 4; p++) begin
         if (!seen[p]) begin
            $display("Error: digit %0d was never selected during a full scan", p);
            errs++;
         end
      end
   endtask

   // ==================================================
   // Main sequence
   // ==================================================

   initial begin
      int base;
      int pulseCount;
      int errs;
      evento      = 1'b0;
      clear       = 1'b0;
      rstN        = 1'b0;
      rngState    = 32'habe2066b;
      testsPassed = 0;
      testsFailed = 0;
      $readmemh("verif/display_testdata.txt", testMem);
      repeat (8) @(posedge clk);
      #1;
      rstN = 1'b1;
      if ($isunknown(testMem[0])) begin
         $display("Error: the test data file could not be read");
         testsFailed++;
      end
      for (int t = 0; t < numTests; t++) begin
         base       = t * fieldsPerTest;
         pulseCount = int'(testMem[base + 1]);
         nextCycle();
         if (testMem[base][0]) begin
            applyClear();
         end
         sendPulses(pulseCount);
         repeat (settleCycles) nextCycle();
         checkScan(base, errs);
         if (errs == 0) begin
            $display("Test %0d (clear %0d, %0d pulses): ok", t, testMem[base][0], pulseCount);
            testsPassed++;
         end else begin
            $display("Test %0d (clear %0d, %0d pulses): %0d errors",
                     t, testMem[base][0], pulseCount, errs);
            testsFailed++;
         end
      end
      $display("Tests run: %0d, passed: %0d, failed: %0d", numTests, testsPassed, testsFailed);
      if (testsFailed == 0) begin
         $display("Simulation PASSED");
      end else begin
         $display("Simulation FAILED");
      end
      $finish;
   end

   // Twice the worst case over all tests.
   initial begin
      int limitCycles;
      @(posedge rstN);
      limitCycles = 16;
      for (int t = 0; t < numTests; t++) begin
         limitCycles += 2 + int'(testMem[t * fieldsPerTest + 1]) * maxPulseCycles
                        + settleCycles + scanCycles;
      end
      limitCycles = 2 * limitCycles;
      repeat (limitCycles) @(posedge clk);
      $display("Timeout: the run did not finish within %0d cycles", limitCycles);
      $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

/* verif/display_testdata.txt */
// clear  pulses  thousands  hundreds  tens  ones   (all hex)
// Pulses add to the running count, clear zeroes it before the pulses.
0 0000 03 03 03 03
0 0005 03 03 03 49
0 0004 03 03 03 19
0 0001 03 03 9F 03
0 0059 03 03 19 19
0 0001 03 9F 03 03
1 0000 03 03 03 03
0 04D2 9F 25 0D 99
0 223D 19 19 19 19
0 0001 9F 9F 9F 9F
1 0003 03 03 03 0D

/* verilog/binToBcd.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module binToBcd (
   input  wire logic                    clk,
   input  wire logic                    rstN,
   input  wire logic                    countReq,
   output logic                         countAck,
   input  wire logic [`COUNT_WIDTH-1:0] countData,
   output logic                         bcdReq,
   input  wire logic                    bcdAck,
   output displayPkg::bcdValueT         bcdData
);

   localparam int stepWidth = $clog2(`COUNT_WIDTH);
   localparam logic [stepWidth-1:0] stepLast = stepWidth'(`COUNT_WIDTH - 1);
   localparam logic [`COUNT_WIDTH-1:0] displayLimit = `DISPLAY_LIMIT;

   typedef enum logic [1:0] {stIdle, stConvert, stSend, stRelease} stateT;

   stateT                   state;
   logic [stepWidth-1:0]    stepCnt;
   logic [`COUNT_WIDTH-1:0] binShift;
   logic [15:0]             bcdShift;
   logic [15:0]             bcdAdj;
   logic [15:0]             bcdNext;
   logic                    overflow;
   logic                    capture;

   // Add 3 to every nibble of 5 or more before the next shift.
   function automatic logic [15:0] addThree(input logic [15:0] bcd);
      logic [15:0] adj;
      adj = bcd;
      for (int i = 0; i < 4; i++) begin
         if (adj[4*i +: 4] >= 4'd5) begin
            adj[4*i +: 4] = adj[4*i +: 4] + 4'd3;
         end
      end
      return adj;
   endfunction

   assign capture = (state == stIdle) && countReq && !countAck;
   assign bcdAdj  = addThree(bcdShift);
   assign bcdNext = {bcdAdj[14:0], binShift[`COUNT_WIDTH-1]};

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state    <= stIdle;
         stepCnt  <= '0;
         countAck <= 1'b0;
         bcdReq   <= 1'b0;
      end else begin
         if (countAck && !countReq) begin
            countAck <= 1'b0;
         end
         case (state)
            stIdle: begin
               if (capture) begin
                  countAck <= 1'b1;
                  stepCnt  <= stepLast;
                  state    <= stConvert;
               end
            end
            stConvert: begin
               if (stepCnt == '0) begin
                  bcdReq <= 1'b1;
                  state  <= stSend;
               end else begin
                  stepCnt <= stepCnt - 1'b1;
               end
            end
            stSend: begin
               if (bcdAck) begin
                  bcdReq <= 1'b0;
                  state  <= stRelease;
               end
            end
            default: begin
               if (!bcdAck) begin
                  state <= stIdle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         binShift <= countData;
         bcdShift <= '0;
         overflow <= countData > displayLimit;
      end else if (state == stConvert) begin
         bcdShift <= bcdNext;
         binShift <= {binShift[`COUNT_WIDTH-2:0], 1'b0};
         if (stepCnt == '0) begin
            bcdData.overflow  <= overflow;
            bcdData.thousands <= bcdNext[15:12];
            bcdData.hundreds  <= bcdNext[11:8];
            bcdData.tens      <= bcdNext[7:4];
            bcdData.ones      <= bcdNext[3:0];
         end
      end
   end

endmodule

`default_nettype wire

/* verilog/displayCounterTop.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module displayCounterTop (
   input  wire logic clk,
   input  wire logic rstN,
   input  wire logic evento,
   input  wire logic clear,
   output logic [7:0] catodo,
   output logic [3:0] anodo
);

   logic                    countReq;
   logic                    countAck;
   logic [`COUNT_WIDTH-1:0] countData;
   logic                    bcdReq;
   logic                    bcdAck;
   displayPkg::bcdValueT    bcdData;
   logic                    segReq;
   logic                    segAck;
   displayPkg::cathodeSetT  segData;

   pulseCounter pulseCounter_inst (
      .clk       (clk),
      .rstN      (rstN),
      .evento    (evento),
      .clear     (clear),
      .countReq  (countReq),
      .countAck  (countAck),
      .countData (countData)
   );

   binToBcd binToBcd_inst (
      .clk       (clk),
      .rstN      (rstN),
      .countReq  (countReq),
      .countAck  (countAck),
      .countData (countData),
      .bcdReq    (bcdReq),
      .bcdAck    (bcdAck),
      .bcdData   (bcdData)
   );

   segmentDecoder segmentDecoder_inst (
      .clk     (clk),
      .rstN    (rstN),
      .bcdReq  (bcdReq),
      .bcdAck  (bcdAck),
      .bcdData (bcdData),
      .segReq  (segReq),
      .segAck  (segAck),
      .segData (segData)
   );

   displayScan displayScan_inst (
      .clk     (clk),
      .rstN    (rstN),
      .segReq  (segReq),
      .segAck  (segAck),
      .segData (segData),
      .catodo  (catodo),
      .anodo   (anodo)
   );

endmodule

`default_nettype wire

/* verilog/displayPkg.sv */
`default_nettype none

package displayPkg;

   // ==================================================
   // BCD values
   // ==================================================

   typedef logic [3:0] bcdDigitT;

   // Overflow sits above the thousands digit.
   typedef struct packed {
      logic     overflow;
      bcdDigitT thousands;
      bcdDigitT hundreds;
      bcdDigitT tens;
      bcdDigitT ones;
   } bcdValueT;

   // ==================================================
   // Segment patterns
   // ==================================================

   typedef logic [7:0] cathodeT;

   // Index 0 is the ones digit.
   typedef cathodeT [3:0] cathodeSetT;

endpackage

`default_nettype wire

/* verilog/displayScan.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module displayScan (
   input  wire logic                   clk,
   input  wire logic                   rstN,
   input  wire logic                   segReq,
   output logic                        segAck,
   input  wire displayPkg::cathodeSetT segData,
   output displayPkg::cathodeT         catodo,
   output logic [3:0]                  anodo
);

   localparam int divWidth = $clog2(`SCAN_PERIOD);
   localparam logic [divWidth-1:0] divLast = divWidth'(`SCAN_PERIOD - 1);

   logic [divWidth-1:0]    divCount;
   logic [1:0]             scanPos;
   displayPkg::cathodeSetT patterns;

   // ==================================================
   // Receiver side that is always ready
   // ==================================================

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         segAck   <= 1'b0;
         patterns <= {4{`SEG_OFF}};
      end else begin
         segAck <= segReq;
         if (segReq && !segAck) begin
            patterns <= segData;
         end
      end
   end

   // ==================================================
   // Digit multiplexing
   // ==================================================

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         divCount <= '0;
         scanPos  <= 2'd0;
         catodo   <= `SEG_OFF;
         anodo    <= 4'b1111;
      end else begin
         if (divCount == divLast) begin
            divCount <= '0;
            scanPos  <= scanPos + 1'b1;
         end else begin
            divCount <= divCount + 1'b1;
         end
         // One anode low at a time, matching the pattern on the cathodes.
         catodo <= patterns[scanPos];
         anodo  <= ~(4'b0001 << scanPos);
      end
   end

endmodule

`default_nettype wire

/* verilog/display_config.svh */
`ifndef DISPLAY_CONFIG_SVH
`define DISPLAY_CONFIG_SVH

// Counter and display sizing.
`define COUNT_WIDTH   14
`define DISPLAY_LIMIT 9999
`define SCAN_PERIOD   16

// Active-low cathode codes. Bit 7 is segment a and bit 0 the decimal point.
`define SEG_OFF       8'b11111111
`define SEG_OVERFLOW  8'b10011111

`define SEG_DIGIT0    8'b00000011
`define SEG_DIGIT1    8'b10011111
`define SEG_DIGIT2    8'b00100101
`define SEG_DIGIT3    8'b00001101
`define SEG_DIGIT4    8'b10011001
`define SEG_DIGIT5    8'b01001001
`define SEG_DIGIT6    8'b01000001
`define SEG_DIGIT7    8'b00011111
`define SEG_DIGIT8    8'b00000001
`define SEG_DIGIT9    8'b00011001

`endif

/* verilog/pulseCounter.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module pulseCounter (
   input  wire logic                    clk,
   input  wire logic                    rstN,
   input  wire logic                    evento,
   input  wire logic                    clear,
   output logic                         countReq,
   input  wire logic                    countAck,
   output logic [`COUNT_WIDTH-1:0]      countData
);

   logic                    evSync1;
   logic                    evSync2;
   logic                    evPrev;
   logic                    pulseEdge;
   logic [`COUNT_WIDTH-1:0] count;
   logic [`COUNT_WIDTH-1:0] lastSent;
   logic                    sentOnce;
   logic                    busy;
   logic                    startSend;

   assign pulseEdge = evSync2 & ~evPrev;

   // The first transfer after reset always goes out, so the display starts at 0000.
   assign startSend = !busy && (!sentOnce || (count != lastSent));

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         evSync1 <= 1'b0;
         evSync2 <= 1'b0;
         evPrev  <= 1'b0;
      end else begin
         evSync1 <= evento;
         evSync2 <= evSync1;
         evPrev  <= evSync2;
      end
   end

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         count <= '0;
      end else if (clear) begin
         count <= '0;
      end else if (pulseEdge) begin
         count <= count + 1'b1;
      end
   end

   // ==================================================
   // Sender side of the count link
   // ==================================================

   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         countReq <= 1'b0;
         busy     <= 1'b0;
         sentOnce <= 1'b0;
         lastSent <= '0;
      end else if (startSend) begin
         countReq <= 1'b1;
         busy     <= 1'b1;
         sentOnce <= 1'b1;
         lastSent <= count;
      end else if (countReq && countAck) begin
         countReq <= 1'b0;
      end else if (busy && !countReq && !countAck) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (startSend) begin
         countData <= count;
      end
   end

endmodule

`default_nettype wire

/* verilog/segmentDecoder.sv */
`timescale 1ns/1ps
`default_nettype none
`include "display_config.svh"

module segmentDecoder (
   input  wire logic                 clk,
   input  wire logic                 rstN,
   input  wire logic                 bcdReq,
   output logic                      bcdAck,
   input  wire displayPkg::bcdValueT bcdData,
   output logic                      segReq,
   input  wire logic                 segAck,
   output displayPkg::cathodeSetT    segData
);

   typedef enum logic [1:0] {stIdle, stDecode, stSend, stRelease} stateT;

   stateT                  state;
   logic                   capture;
   displayPkg::bcdValueT   bcdReg;
   displayPkg::cathodeSetT decoded;

   function automatic displayPkg::cathodeT digitPattern(input displayPkg::bcdDigitT digit);
      case (digit)
         4'd0:    return `SEG_DIGIT0;
         4'd1:    return `SEG_DIGIT1;
         4'd2:    return `SEG_DIGIT2;
         4'd3:    return `SEG_DIGIT3;
         4'd4:    return `SEG_DIGIT4;
         4'd5:    return `SEG_DIGIT5;
         4'd6:    return `SEG_DIGIT6;
         4'd7:    return `SEG_DIGIT7;
         4'd8:    return `SEG_DIGIT8;
         4'd9:    return `SEG_DIGIT9;
         default: return `SEG_OVERFLOW;
      endcase
   endfunction

   assign capture = (state == stIdle) && bcdReq && !bcdAck;

   always_comb begin
      if (bcdReg.overflow) begin
         decoded = {4{`SEG_OVERFLOW}};
      end else begin
         decoded[0] = digitPattern(bcdReg.ones);
         decoded[1] = digitPattern(bcdReg.tens);
         decoded[2] = digitPattern(bcdReg.hundreds);
         decoded[3] = digitPattern(bcdReg.thousands);
      end
   end

   // A new set is only accepted once the previous one has left on the output link.
   always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
         state  <= stIdle;
         bcdAck <= 1'b0;
         segReq <= 1'b0;
      end else begin
         if (bcdAck && !bcdReq) begin
            bcdAck <= 1'b0;
         end
         case (state)
            stIdle: begin
               if (capture) begin
                  bcdAck <= 1'b1;
                  state  <= stDecode;
               end
            end
            stDecode: begin
               segReq <= 1'b1;
               state  <= stSend;
            end
            stSend: begin
               if (segAck) begin
                  segReq <= 1'b0;
                  state  <= stRelease;
               end
            end
            default: begin
               if (!segAck) begin
                  state <= stIdle;
               end
            end
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (capture) begin
         bcdReg <= bcdData;
      end
      if (state == stDecode) begin
         segData <= decoded;
      end
   end

endmodule

`default_nettype wire
